// File: isa_pkg.sv
package isa_pkg;

    localparam int WORD_W     = 16;
    localparam int REG_ADDR_W = 2;
    localparam int NUM_REGS   = 4;

    // Instruction field positions
    localparam int OP_HI  = 15;
    localparam int OP_LO  = 12;
    localparam int RS_HI  = 11;
    localparam int RS_LO  = 10;
    localparam int RT_HI  = 9;
    localparam int RT_LO  = 8;
    localparam int RD_HI  = 7;
    localparam int RD_LO  = 6;
    localparam int FN_HI  = 5;
    localparam int FN_LO  = 0;
    localparam int IMM_HI = 7;
    localparam int IMM_LO = 0;
    localparam int TGT_HI = 11;
    localparam int TGT_LO = 0;

    // JAL writes its return address here
    localparam logic [REG_ADDR_W-1:0] LINK_REG = 2'd2;

    typedef enum logic [3:0] {
        BNE   = 4'd0,
        BEQ   = 4'd1,
        ADI   = 4'd4,
        LHI   = 4'd6,
        LWD   = 4'd7,
        SWD   = 4'd8,
        JMP   = 4'd9,
        JAL   = 4'd10,
        RTYPE = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        ADD    = 6'd0,
        SUB    = 6'd1,
        AND_OP = 6'd2,
        ORR    = 6'd3,
        NOT_OP = 6'd4,
        WWD    = 6'd28,
        HLT    = 6'd29
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_LHI
    } alu_op_e;

    // Unassigned opcode 11, decodes as a bubble
    localparam logic [WORD_W-1:0] NOP_INST = 16'hB000;

endpackage

// File: pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [1:0] {
        DEST_RD,
        DEST_RT,
        DEST_LINK
    } dest_sel_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_WB,
        FWD_MEM
    } fwd_sel_e;

    typedef struct packed {
        isa_pkg::alu_op_e alu_op;
        logic             alu_src_imm;
        logic             mem_read;
        logic             mem_write;
        logic             reg_write;
        dest_sel_e        dest_sel;
        logic             pc_to_reg;
        logic             is_branch;
        logic             is_jump;
        logic             is_wwd;
        logic             is_halt;
        logic             valid;
    } ctrl_t;

    typedef struct packed {
        logic [isa_pkg::WORD_W-1:0] inst;
        logic [isa_pkg::WORD_W-1:0] pc_plus1;
    } if_id_t;

    typedef struct packed {
        ctrl_t                          ctrl;
        logic [isa_pkg::WORD_W-1:0]     rs_val;
        logic [isa_pkg::WORD_W-1:0]     rt_val;
        logic [isa_pkg::WORD_W-1:0]     imm;
        logic [isa_pkg::REG_ADDR_W-1:0] rs;
        logic [isa_pkg::REG_ADDR_W-1:0] rt;
        logic [isa_pkg::REG_ADDR_W-1:0] dest;
        logic [isa_pkg::WORD_W-1:0]     pc_plus1;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                          ctrl;
        logic [isa_pkg::WORD_W-1:0]     alu_result;
        logic [isa_pkg::WORD_W-1:0]     store_data;
        logic [isa_pkg::REG_ADDR_W-1:0] dest;
        logic [isa_pkg::WORD_W-1:0]     pc_plus1;
        logic [isa_pkg::WORD_W-1:0]     wwd_val;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t                          ctrl;
        logic [isa_pkg::WORD_W-1:0]     wb_val;
        logic [isa_pkg::REG_ADDR_W-1:0] dest;
        logic [isa_pkg::WORD_W-1:0]     wwd_val;
    } mem_wb_t;

    typedef struct packed {
        logic [isa_pkg::WORD_W-1:0] addr;
        logic [isa_pkg::WORD_W-1:0] data;
    } load_req_t;

endpackage

// File: control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic [isa_pkg::WORD_W-1:0] inst,
    output pipe_pkg::ctrl_t            ctrl
);
    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_e op;
    funct_e  fn;

    assign op = opcode_e'(inst[OP_HI:OP_LO]);
    assign fn = funct_e'(inst[FN_HI:FN_LO]);

    always_comb begin
        ctrl          = '0;
        ctrl.alu_op   = ALU_ADD;
        ctrl.dest_sel = DEST_RT;
        ctrl.valid    = 1'b1;
        case (op)
            ADI: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            LHI: begin
                ctrl.alu_op      = ALU_LHI;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            LWD: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            SWD: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            BNE, BEQ: ctrl.is_branch = 1'b1;
            JMP:      ctrl.is_jump = 1'b1;
            JAL: begin
                ctrl.is_jump   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest_sel  = DEST_LINK;
                ctrl.pc_to_reg = 1'b1;
            end
            RTYPE: begin
                ctrl.dest_sel  = DEST_RD;
                ctrl.reg_write = fn inside {ADD, SUB, AND_OP, ORR, NOT_OP};
                case (fn)
                    ADD:     ctrl.alu_op = ALU_ADD;
                    SUB:     ctrl.alu_op = ALU_SUB;
                    AND_OP:  ctrl.alu_op = ALU_AND;
                    ORR:     ctrl.alu_op = ALU_OR;
                    NOT_OP:  ctrl.alu_op = ALU_NOT;
                    WWD:     ctrl.is_wwd = 1'b1;
                    HLT:     ctrl.is_halt = 1'b1;
                    default: ctrl.valid = 1'b0;
                endcase
            end
            // NOP_INST lands here too
            default: ctrl.valid = 1'b0;
        endcase
    end

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic [isa_pkg::REG_ADDR_W-1:0] rs_addr,
    input  logic [isa_pkg::REG_ADDR_W-1:0] rt_addr,
    output logic [isa_pkg::WORD_W-1:0]     rs_data,
    output logic [isa_pkg::WORD_W-1:0]     rt_data,
    input  logic                           wr_en,
    input  logic [isa_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [isa_pkg::WORD_W-1:0]     wr_data
);
    import isa_pkg::*;

    logic [WORD_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // WB write seen by ID in the same cycle
    assign rs_data = (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  isa_pkg::alu_op_e           op,
    input  logic [isa_pkg::WORD_W-1:0] a,
    input  logic [isa_pkg::WORD_W-1:0] b,
    output logic [isa_pkg::WORD_W-1:0] result
);
    import isa_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_NOT: result = ~a;
            // Low byte of b moves to the upper byte
            ALU_LHI: result = {b[WORD_W/2-1:0], {(WORD_W/2){1'b0}}};
            default: result = '0;
        endcase
    end

endmodule

// File: hazard_forward.sv
`timescale 1ns/1ps

module hazard_forward (
    input  logic [isa_pkg::WORD_W-1:0] id_inst,
    input  pipe_pkg::id_ex_t           id_ex,
    input  pipe_pkg::ex_mem_t          ex_mem,
    input  pipe_pkg::mem_wb_t          mem_wb,
    output logic                       stall,
    output pipe_pkg::fwd_sel_e         fwd_a,
    output pipe_pkg::fwd_sel_e         fwd_b,
    output pipe_pkg::fwd_sel_e         id_fwd_a,
    output pipe_pkg::fwd_sel_e         id_fwd_b
);
    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_e               op;
    funct_e                fn;
    logic [REG_ADDR_W-1:0] id_rs;
    logic [REG_ADDR_W-1:0] id_rt;
    logic                  uses_rs;
    logic                  uses_rt;
    logic                  is_branch;
    logic                  load_use;
    logic                  branch_wait;

    // MEM result wins over WB
    function automatic fwd_sel_e pick(input logic [REG_ADDR_W-1:0] src);
        if (ex_mem.ctrl.reg_write && ex_mem.dest == src) begin
            return FWD_MEM;
        end
        if (mem_wb.ctrl.reg_write && mem_wb.dest == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign op    = opcode_e'(id_inst[OP_HI:OP_LO]);
    assign fn    = funct_e'(id_inst[FN_HI:FN_LO]);
    assign id_rs = id_inst[RS_HI:RS_LO];
    assign id_rt = id_inst[RT_HI:RT_LO];

    assign is_branch = (op == BNE) || (op == BEQ);
    assign uses_rs   = op inside {ADI, LWD, SWD, BNE, BEQ, RTYPE};
    assign uses_rt   = (op inside {SWD, BNE, BEQ})
                    || (op == RTYPE && fn inside {ADD, SUB, AND_OP, ORR});

    assign load_use = id_ex.ctrl.mem_read
                   && ((uses_rs && id_ex.dest == id_rs) || (uses_rt && id_ex.dest == id_rt));

    // Comparator in ID cannot see a result still in EX
    assign branch_wait = is_branch && id_ex.ctrl.reg_write
                      && (id_ex.dest == id_rs || id_ex.dest == id_rt);

    assign stall = load_use || branch_wait;

    always_comb begin
        fwd_a    = pick(id_ex.rs);
        fwd_b    = pick(id_ex.rt);
        id_fwd_a = pick(id_rs);
        id_fwd_b = pick(id_rt);
    end

endmodule

// File: cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
    input  logic                       clk,
    input  logic                       reset_n,
    output logic [isa_pkg::WORD_W-1:0] fetch_addr,
    input  logic [isa_pkg::WORD_W-1:0] fetch_data,
    output logic [isa_pkg::WORD_W-1:0] data_addr,
    output logic [isa_pkg::WORD_W-1:0] data_wdata,
    output logic                       data_read,
    output logic                       data_write,
    input  logic [isa_pkg::WORD_W-1:0] data_rdata,
    output logic [isa_pkg::WORD_W-1:0] output_port,
    output logic                       output_valid,
    output logic [isa_pkg::WORD_W-1:0] num_inst,
    output logic                       is_halted
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [WORD_W-1:0]     pc;
    logic [WORD_W-1:0]     pc_plus1;
    if_id_t                if_id;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;
    mem_wb_t               mem_wb;
    logic [WORD_W-1:0]     retired;

    ctrl_t                 id_ctrl;
    logic [REG_ADDR_W-1:0] id_rs;
    logic [REG_ADDR_W-1:0] id_rt;
    logic [REG_ADDR_W-1:0] id_dest;
    logic [WORD_W-1:0]     rs_data;
    logic [WORD_W-1:0]     rt_data;
    logic [WORD_W-1:0]     id_imm;
    logic [WORD_W-1:0]     id_a;
    logic [WORD_W-1:0]     id_b;
    logic                  is_beq;
    logic                  taken;
    logic                  redirect;
    logic [WORD_W-1:0]     target;
    logic                  stall;
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;
    fwd_sel_e              id_fwd_a;
    fwd_sel_e              id_fwd_b;
    logic [WORD_W-1:0]     ex_a;
    logic [WORD_W-1:0]     ex_b_reg;
    logic [WORD_W-1:0]     ex_b;
    logic [WORD_W-1:0]     alu_out;
    logic [WORD_W-1:0]     mem_val;

    function automatic logic [WORD_W-1:0] fwd_mux(
        input fwd_sel_e          sel,
        input logic [WORD_W-1:0] reg_val,
        input logic [WORD_W-1:0] mem_stage,
        input logic [WORD_W-1:0] wb_stage
    );
        case (sel)
            FWD_MEM: return mem_stage;
            FWD_WB:  return wb_stage;
            default: return reg_val;
        endcase
    endfunction

    assign fetch_addr = pc;
    assign pc_plus1   = pc + 1'b1;

    ////////////////////////////////////////////////////////////
    // Decode, register read and branch resolution

    control_unit control_unit_inst (
        .inst (if_id.inst),
        .ctrl (id_ctrl)
    );

    assign id_rs  = if_id.inst[RS_HI:RS_LO];
    assign id_rt  = if_id.inst[RT_HI:RT_LO];
    assign id_imm = {{(WORD_W-IMM_HI-1){if_id.inst[IMM_HI]}}, if_id.inst[IMM_HI:IMM_LO]};

    always_comb begin
        case (id_ctrl.dest_sel)
            DEST_RD:   id_dest = if_id.inst[RD_HI:RD_LO];
            DEST_LINK: id_dest = LINK_REG;
            default:   id_dest = id_rt;
        endcase
    end

    register_file register_file_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .rs_addr (id_rs),
        .rt_addr (id_rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (mem_wb.ctrl.reg_write),
        .wr_addr (mem_wb.dest),
        .wr_data (mem_wb.wb_val)
    );

    hazard_forward hazard_forward_inst (
        .id_inst  (if_id.inst),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .stall    (stall),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .id_fwd_a (id_fwd_a),
        .id_fwd_b (id_fwd_b)
    );

    assign id_a   = fwd_mux(id_fwd_a, rs_data, mem_val, mem_wb.wb_val);
    assign id_b   = fwd_mux(id_fwd_b, rt_data, mem_val, mem_wb.wb_val);
    assign is_beq = opcode_e'(if_id.inst[OP_HI:OP_LO]) == BEQ;
    assign taken  = id_ctrl.is_branch && ((id_a == id_b) == is_beq);

    // Jumps keep the upper bits of the next PC
    assign target = id_ctrl.is_jump
                  ? {if_id.pc_plus1[WORD_W-1:TGT_HI+1], if_id.inst[TGT_HI:TGT_LO]}
                  : if_id.pc_plus1 + id_imm;

    // A stalled branch resolves once its operands are ready
    assign redirect = (id_ctrl.is_jump || taken) && !stall;

    ////////////////////////////////////////////////////////////
    // Execute and memory

    assign ex_a     = fwd_mux(fwd_a, id_ex.rs_val, mem_val, mem_wb.wb_val);
    assign ex_b_reg = fwd_mux(fwd_b, id_ex.rt_val, mem_val, mem_wb.wb_val);
    assign ex_b     = id_ex.ctrl.alu_src_imm ? id_ex.imm : ex_b_reg;

    alu alu_inst (
        .op     (id_ex.ctrl.alu_op),
        .a      (ex_a),
        .b      (ex_b),
        .result (alu_out)
    );

    // Instructions behind a halt never touch memory
    assign data_addr  = ex_mem.alu_result;
    assign data_wdata = ex_mem.store_data;
    assign data_read  = ex_mem.ctrl.mem_read && !is_halted;
    assign data_write = ex_mem.ctrl.mem_write && !is_halted;

    assign mem_val = ex_mem.ctrl.mem_read  ? data_rdata
                   : ex_mem.ctrl.pc_to_reg ? ex_mem.pc_plus1
                   : ex_mem.alu_result;

    ////////////////////////////////////////////////////////////
    // Write-back and status

    assign is_halted    = mem_wb.ctrl.valid && mem_wb.ctrl.is_halt;
    assign output_valid = mem_wb.ctrl.valid && mem_wb.ctrl.is_wwd;
    assign output_port  = mem_wb.wwd_val;
    assign num_inst     = retired;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc      <= '0;
            if_id   <= '{inst: NOP_INST, pc_plus1: '0};
            id_ex   <= '0;
            ex_mem  <= '0;
            mem_wb  <= '0;
            retired <= '0;
        end else if (!is_halted) begin
            if (redirect) begin
                pc         <= target;
                if_id.inst <= NOP_INST;
            end else if (!stall) begin
                pc    <= pc_plus1;
                if_id <= '{inst: fetch_data, pc_plus1: pc_plus1};
            end

            if (stall) begin
                id_ex <= '0;
            end else begin
                id_ex <= '{ctrl: id_ctrl, rs_val: rs_data, rt_val: rt_data, imm: id_imm,
                           rs: id_rs, rt: id_rt, dest: id_dest, pc_plus1: if_id.pc_plus1};
            end

            ex_mem <= '{ctrl: id_ex.ctrl, alu_result: alu_out, store_data: ex_b_reg,
                        dest: id_ex.dest, pc_plus1: id_ex.pc_plus1, wwd_val: ex_a};
            mem_wb <= '{ctrl: ex_mem.ctrl, wb_val: mem_val, dest: ex_mem.dest,
                        wwd_val: ex_mem.wwd_val};

            // Counted as it enters WB
            if (ex_mem.ctrl.valid) begin
                retired <= retired + 1'b1;
            end
        end
    end

    a_mem_excl: assert property (@(posedge clk) disable iff (reset_n)
        !(data_read && data_write));

    a_halt_pc: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |=> $stable(pc));

endmodule

// File: memory_unit.sv
`timescale 1ns/1ps

module memory_unit #(
    parameter int MEM_WORDS = 256
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       load_valid,
    input  pipe_pkg::load_req_t        load_req,
    output logic                       load_ready,
    input  logic [isa_pkg::WORD_W-1:0] fetch_addr,
    output logic [isa_pkg::WORD_W-1:0] fetch_data,
    input  logic [isa_pkg::WORD_W-1:0] data_addr,
    input  logic [isa_pkg::WORD_W-1:0] data_wdata,
    input  logic                       data_read,
    input  logic                       data_write,
    output logic [isa_pkg::WORD_W-1:0] data_rdata
);
    import isa_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    logic [WORD_W-1:0] imem [MEM_WORDS];
    logic [WORD_W-1:0] dmem [MEM_WORDS];
    logic              load_fire;

    // Program load only while the core is held in reset
    assign load_ready = reset_n;
    assign load_fire  = load_valid && load_ready;

    always_ff @(posedge clk) begin
        if (load_fire && load_req.addr < MEM_WORDS) begin
            imem[load_req.addr[AW-1:0]] <= load_req.data;
            dmem[load_req.addr[AW-1:0]] <= load_req.data;
        end else if (data_write && data_addr < MEM_WORDS) begin
            dmem[data_addr[AW-1:0]] <= data_wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // Combinational reads

    assign fetch_data = (fetch_addr < MEM_WORDS) ? imem[fetch_addr[AW-1:0]] : NOP_INST;
    assign data_rdata = (data_read && data_addr < MEM_WORDS) ? dmem[data_addr[AW-1:0]] : '0;

    // Loader must have let go before the core starts
    a_load_in_reset: assert property (@(posedge clk) load_valid |-> reset_n);

endmodule

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       load_valid,
    input  pipe_pkg::load_req_t        load_req,
    output logic                       load_ready,
    output logic [isa_pkg::WORD_W-1:0] output_port,
    output logic                       output_valid,
    output logic [isa_pkg::WORD_W-1:0] num_inst,
    output logic                       is_halted
);
    import isa_pkg::*;

    logic [WORD_W-1:0] fetch_addr;
    logic [WORD_W-1:0] fetch_data;
    logic [WORD_W-1:0] data_addr;
    logic [WORD_W-1:0] data_wdata;
    logic [WORD_W-1:0] data_rdata;
    logic              data_read;
    logic              data_write;

    cpu_core cpu_core_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_read    (data_read),
        .data_write   (data_write),
        .data_rdata   (data_rdata),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

    memory_unit #(
        .MEM_WORDS (MEM_WORDS)
    ) memory_unit_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .load_valid (load_valid),
        .load_req   (load_req),
        .load_ready (load_ready),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_read  (data_read),
        .data_write (data_write),
        .data_rdata (data_rdata)
    );

endmodule

// File: tb_programs.svh
// Test programs, one instruction word per entry starting at address 0
// Each program is followed by its WWD outputs in order and its retire count

// LHI and ADI build 0x1234, WWD shows it
logic [15:0] load_prog [$] = '{
    16'h6012,  // LHI r0, 0x12
    16'h4034,  // ADI r0, r0, 0x34
    16'hF01C,  // WWD r0
    16'hF01D   // HLT
};
logic [15:0] load_outs [$] = '{16'h1234};
localparam int LOAD_RETIRED = 4;

// Store, dependent load, then a use right behind the load
logic [15:0] load_use_prog [$] = '{
    16'h4140,  // ADI r1, r0, 0x40
    16'h42A5,  // ADI r2, r0, 0xA5    r2 = 0xFFA5
    16'h8601,  // SWD r2, 1(r1)       mem[0x41] = 0xFFA5
    16'h7701,  // LWD r3, 1(r1)
    16'hFF00,  // ADD r0, r3, r3      stalls one cycle
    16'hFC1C,  // WWD r3
    16'hF01C,  // WWD r0
    16'hF01D   // HLT
};
logic [15:0] load_use_outs [$] = '{16'hFFA5, 16'hFF4A};
localparam int LOAD_USE_RETIRED = 8;

// Taken and not-taken BEQ and BNE
logic [15:0] branch_prog [$] = '{
    16'h4105,  // 0  ADI r1, r0, 5
    16'h4205,  // 1  ADI r2, r0, 5
    16'h1601,  // 2  BEQ r1, r2, +1   taken to 4
    16'hF41C,  // 3  WWD r1           skipped
    16'h0601,  // 4  BNE r1, r2, +1   not taken
    16'hF81C,  // 5  WWD r2
    16'h4A01,  // 6  ADI r2, r2, 1
    16'h1601,  // 7  BEQ r1, r2, +1   not taken
    16'hF81C,  // 8  WWD r2
    16'h0602,  // 9  BNE r1, r2, +2   taken to 12
    16'hF41C,  // 10 WWD r1           skipped
    16'hF01D,  // 11 HLT              skipped
    16'hF41C,  // 12 WWD r1
    16'hF01D   // 13 HLT
};
logic [15:0] branch_outs [$] = '{16'h0005, 16'h0006, 16'h0005};
localparam int BRANCH_RETIRED = 11;

// JMP over dead code, JAL links r2 to its address plus one
logic [15:0] jump_prog [$] = '{
    16'h4107,  // 0  ADI r1, r0, 7
    16'h9004,  // 1  JMP 4
    16'hF41C,  // 2  WWD r1           skipped
    16'hF01D,  // 3  HLT              skipped
    16'hA008,  // 4  JAL 8            r2 = 5
    16'hF41C,  // 5  WWD r1           skipped
    16'hF01D,  // 6  HLT              skipped
    16'hF01D,  // 7  HLT              skipped
    16'hF81C,  // 8  WWD r2
    16'hF41C,  // 9  WWD r1
    16'hF01D   // 10 HLT
};
logic [15:0] jump_outs [$] = '{16'h0005, 16'h0007};
localparam int JUMP_RETIRED = 6;

// Code behind HLT must never show up
logic [15:0] halt_prog [$] = '{
    16'h4103,  // ADI r1, r0, 3
    16'hF41C,  // WWD r1
    16'hF01D,  // HLT
    16'hF41C,  // WWD r1
    16'h4501,  // ADI r1, r1, 1
    16'hF41C   // WWD r1
};
logic [15:0] halt_outs [$] = '{16'h0003};
localparam int HALT_RETIRED = 3;

// File: tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int MEM_WORDS    = 256;
    localparam int LOAD_TIMEOUT = 20;
    localparam int RUN_TIMEOUT  = 1000;
    localparam int HOLD_CYCLES  = 20;
    localparam int ARITH_ROUNDS = 4;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        load_valid;
    load_req_t   load_req;
    logic        load_ready;
    logic [15:0] output_port;
    logic        output_valid;
    logic [15:0] num_inst;
    logic        is_halted;

    logic [15:0] seen [$];
    logic [31:0] lfsr   = 32'h71e7_c0b9;
    int          checks = 0;
    int          errors = 0;

    `include "tb_programs.svh"

    always #5 clk = ~clk;

    cpu_top #(
        .MEM_WORDS (MEM_WORDS)
    ) cpu_top_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .load_valid   (load_valid),
        .load_req     (load_req),
        .load_ready   (load_ready),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

    ////////////////////////////////////////////////////////////
    // Stimulus helpers

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_bit()};
        end
        return b;
    endfunction

    function automatic logic [15:0] itype_word(input opcode_e op, input logic [1:0] rs,
                                               input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] rtype_word(input logic [1:0] rs, input logic [1:0] rt,
                                               input logic [1:0] rd, input funct_e fn);
        return {RTYPE, rs, rt, rd, fn};
    endfunction

    task automatic compare_word(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s: got 16'h%h, expected 16'h%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic confirm(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic compare_outputs(input logic [15:0] exp [$]);
        confirm(seen.size() == exp.size(), $sformatf(
            "Saw %0d WWD outputs where %0d were expected", seen.size(), exp.size()));
        for (int i = 0; i < exp.size() && i < seen.size(); i++) begin
            compare_word($sformatf("output_port[%0d]", i), seen[i], exp[i]);
        end
    endtask

    // Core stays in reset while the words go in, then starts at address 0
    task automatic load_program(input logic [15:0] words [$]);
        int waited;
        @(posedge clk);
        #1;
        reset_n = 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < words.size(); i++) begin
            #1;
            load_valid = 1'b1;
            load_req   = '{addr: 16'(i), data: words[i]};
            waited     = 0;
            while (!load_ready && waited < LOAD_TIMEOUT) begin
                @(posedge clk);
                #1;
                waited++;
            end
            confirm(load_ready, "load_ready stayed low while reset was held");
            @(posedge clk);
        end
        #1;
        load_valid = 1'b0;
        reset_n    = 1'b0;
    endtask

    task automatic run_and_collect(output bit done);
        int cycles;
        seen.delete();
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            if (output_valid) begin
                seen.push_back(output_port);
            end
            if (is_halted) begin
                done = 1'b1;
            end
            cycles++;
        end
        confirm(done, "is_halted did not rise before the run timeout");
    endtask

    task automatic run_program(input logic [15:0] prog [$], input logic [15:0] outs [$],
                               input int retired);
        bit done;
        load_program(prog);
        run_and_collect(done);
        compare_outputs(outs);
        compare_word("num_inst", num_inst, 16'(retired));
    endtask

    task automatic report_test(input string name, input int start);
        if (errors == start) begin
            $display("Test %-16s passed", name);
        end else begin
            $display("Test %-16s failed with %0d error(s)", name, errors - start);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests

    task automatic verify_program_load();
        int start;
        bit done;
        start = errors;
        @(posedge clk);
        #1;
        reset_n = 1'b1;
        @(posedge clk);
        #1;
        compare_word("load_ready", 16'(load_ready), 16'h0001);
        load_program(load_prog);
        #1;
        compare_word("load_ready", 16'(load_ready), 16'h0000);
        run_and_collect(done);
        compare_outputs(load_outs);
        compare_word("num_inst", num_inst, 16'(LOAD_RETIRED));
        report_test("program load", start);
    endtask

    // Results go to r3 so r0 stays zero across rounds
    task automatic arith_forwarding();
        logic [15:0] prog [$];
        logic [15:0] outs [$];
        logic [7:0]  a;
        logic [7:0]  b;
        logic [15:0] av;
        logic [15:0] bv;
        int          start;
        start = errors;
        for (int r = 0; r < ARITH_ROUNDS; r++) begin
            a  = random_byte();
            b  = random_byte();
            av = {{8{a[7]}}, a};
            bv = {{8{b[7]}}, b};
            prog.push_back(itype_word(ADI, 2'd0, 2'd1, a));
            prog.push_back(itype_word(ADI, 2'd0, 2'd2, b));
            prog.push_back(rtype_word(2'd1, 2'd2, 2'd3, ADD));
            prog.push_back(rtype_word(2'd3, 2'd0, 2'd0, WWD));
            prog.push_back(rtype_word(2'd1, 2'd2, 2'd3, SUB));
            prog.push_back(rtype_word(2'd3, 2'd0, 2'd0, WWD));
            prog.push_back(rtype_word(2'd1, 2'd2, 2'd3, AND_OP));
            prog.push_back(rtype_word(2'd3, 2'd0, 2'd0, WWD));
            prog.push_back(rtype_word(2'd1, 2'd2, 2'd3, ORR));
            prog.push_back(rtype_word(2'd3, 2'd0, 2'd0, WWD));
            prog.push_back(rtype_word(2'd1, 2'd0, 2'd3, NOT_OP));
            prog.push_back(rtype_word(2'd3, 2'd0, 2'd0, WWD));
            prog.push_back(itype_word(LHI, 2'd0, 2'd3, a));
            prog.push_back(itype_word(ADI, 2'd3, 2'd3, b));
            prog.push_back(rtype_word(2'd3, 2'd0, 2'd0, WWD));
            outs.push_back(av + bv);
            outs.push_back(av - bv);
            outs.push_back(av & bv);
            outs.push_back(av | bv);
            outs.push_back(~av);
            outs.push_back({a, 8'h00} + bv);
        end
        prog.push_back(rtype_word(2'd0, 2'd0, 2'd0, HLT));
        run_program(prog, outs, 15 * ARITH_ROUNDS + 1);
        report_test("arithmetic", start);
    endtask

    task automatic load_use_stall();
        int start;
        start = errors;
        run_program(load_use_prog, load_use_outs, LOAD_USE_RETIRED);
        report_test("load-use", start);
    endtask

    task automatic branch_outcomes();
        int start;
        start = errors;
        run_program(branch_prog, branch_outs, BRANCH_RETIRED);
        report_test("branches", start);
    endtask

    task automatic jump_and_link();
        int start;
        start = errors;
        run_program(jump_prog, jump_outs, JUMP_RETIRED);
        report_test("jumps", start);
    endtask

    task automatic halt_freeze();
        int          start;
        int          pulses;
        int          drift;
        logic [15:0] count_at_halt;
        start  = errors;
        pulses = 0;
        drift  = 0;
        run_program(halt_prog, halt_outs, HALT_RETIRED);
        count_at_halt = num_inst;
        // Watch a window after the halt
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            if (output_valid) begin
                pulses++;
            end
            if (!is_halted || num_inst !== count_at_halt) begin
                drift++;
            end
        end
        confirm(pulses == 0, "output_valid pulsed after the halt");
        confirm(drift == 0, "is_halted dropped or num_inst moved after the halt");
        report_test("halt", start);
    endtask

    initial begin
        reset_n    = 1'b1;
        load_valid = 1'b0;
        load_req   = '0;
        verify_program_load();
        arith_forwarding();
        load_use_stall();
        branch_outcomes();
        jump_and_link();
        halt_freeze();
        $display("Summary: 6 tests, %0d checks, %0d failed", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
control_unit.sv
register_file.sv
alu.sv
hazard_forward.sv
cpu_core.sv
memory_unit.sv
cpu_top.sv
tb_cpu_top.sv
